//--- Makefile
# Verilator flow for the data memory testbench
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
TOP        ?= tb_data_mem
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
PASS_MSG   ?= Finished with no errors
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- backing_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word RAM with byte lanes and one cycle read
// Contents start at zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_cfg.svh"

module backing_ram (
    input  logic                   clk,
    input  logic [3:0]             we,     // One bit per byte lane
    input  logic [`RAM_ADDR_W-1:0] addr,   // Word address
    input  logic [`MEM_DATA_W-1:0] wdata,
    output logic [`MEM_DATA_W-1:0] rdata
);

    // Storage
    logic [`MEM_DATA_W-1:0] mem [`RAM_WORDS] = '{default: '0};

    always_ff @(posedge clk) begin
        // Lane writes
        for (int b = 0; b < `MEM_DATA_W / 8; b++) begin
            if (we[b]) begin
                mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
        rdata <= mem[addr];  // Read first on a same-address write
    end

endmodule

//--- cache_ctrl_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache control and hit or miss counters
// Counters saturate and clear on any ctrl write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_cfg.svh"

module cache_ctrl_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cfg_we,     // Single cycle strobe
    input  cache_pkg::cfg_reg_e    cfg_addr,
    input  logic [`MEM_DATA_W-1:0] cfg_wdata,
    input  cache_pkg::cache_evt_t  evt,
    output logic [`MEM_DATA_W-1:0] cfg_rdata,
    output cache_pkg::cache_ctl_t  ctl
);
    import cache_pkg::*;

    logic                   enable_q;
    logic                   inval_q;
    logic [`MEM_DATA_W-1:0] hit_cnt;
    logic [`MEM_DATA_W-1:0] miss_cnt;
    logic                   ctrl_wr;

    assign ctrl_wr = cfg_we && (cfg_addr == REG_CTRL);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_q <= 1'b1;  // Cache on out of reset
            inval_q  <= 1'b0;
            hit_cnt  <= '0;
            miss_cnt <= '0;
        end else begin
            inval_q <= ctrl_wr && cfg_wdata[1];  // Self clearing
            if (ctrl_wr) begin
                enable_q <= cfg_wdata[0];
                hit_cnt  <= '0;
                miss_cnt <= '0;
            end else begin
                if (evt.hit && !(&hit_cnt))
                    hit_cnt <= hit_cnt + 1'b1;
                if (evt.miss && !(&miss_cnt))
                    miss_cnt <= miss_cnt + 1'b1;
            end
        end
    end

    assign ctl = '{enable: enable_q, invalidate: inval_q};

    // Register read back
    always_comb begin
        case (cfg_addr)
            REG_CTRL:       cfg_rdata = {{(`MEM_DATA_W-1){1'b0}}, enable_q};  // Bit 1 reads 0
            REG_HIT_COUNT:  cfg_rdata = hit_cnt;
            REG_MISS_COUNT: cfg_rdata = miss_cnt;
            default:        cfg_rdata = '0;
        endcase
    end

endmodule

//--- cache_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache internal types and register map
// Valid bits live outside cache_line_t
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mem_cfg.svh"

package cache_pkg;

    // Tag on top of the data words like the address layout
    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]                 tag;
        logic [`LINE_WORDS-1:0][`MEM_DATA_W-1:0] data;  // Word 0 in the low bits
    } cache_line_t;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_FILL    = 2'd1,   // Line fill or single bypass read
        ST_RESPOND = 2'd2
    } fill_state_e;

    // Register addresses on the config port
    typedef enum logic [1:0] {
        REG_CTRL       = 2'd0,
        REG_HIT_COUNT  = 2'd1,
        REG_MISS_COUNT = 2'd2
    } cfg_reg_e;

    typedef struct packed {
        logic enable;      // Level
        logic invalidate;  // Single cycle pulse
    } cache_ctl_t;

    // One pulse per accepted read with the cache enabled
    typedef struct packed {
        logic hit;
        logic miss;
    } cache_evt_t;

endpackage

//--- data_mem_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Protocol checks on the processor port of dcache_core
// Bound into the core from the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_cfg.svh"

module data_mem_asserts (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_access_pkg::mem_req_t req,
    input  logic                     ready,
    input  mem_access_pkg::mem_rsp_t rsp
);
    import mem_access_pkg::*;

    logic acc_rd;   // Read accepted this cycle
    logic pending;  // Accepted read still waiting for its response

    assign acc_rd = req.valid && ready && !req.we;

    always_ff @(posedge clk) begin
        if (!rst_n)
            pending <= 1'b0;
        else if (acc_rd)
            pending <= 1'b1;  // Also covers a new read in the respond cycle
        else if (rsp.valid)
            pending <= 1'b0;
    end

    strobe_needs_ready: assert property (
        @(posedge clk) disable iff (!rst_n) req.valid |-> ready
    ) else $error("Request strobe while ready is low");

    natural_alignment: assert property (
        @(posedge clk) disable iff (!rst_n)
        req.valid |-> !(req.size == SIZE_HALF && req.addr[0])
                   && !(req.size == SIZE_WORD && req.addr[1:0] != 2'b00)
    ) else $error("Misaligned half or word access");

    // One response per read, and it comes before or with ready high again
    one_rsp_per_read: assert property (
        @(posedge clk) disable iff (!rst_n) rsp.valid == (pending && ready)
    ) else $error("Read response missing, early or duplicated");

endmodule

//--- data_mem_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data memory with cache and control registers
// Requester must watch ready before strobing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_cfg.svh"

module data_mem_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_access_pkg::mem_req_t req,
    output mem_access_pkg::mem_rsp_t rsp,
    output logic                     ready,
    input  logic                     cfg_we,
    input  cache_pkg::cfg_reg_e      cfg_addr,
    input  logic [`MEM_DATA_W-1:0]   cfg_wdata,
    output logic [`MEM_DATA_W-1:0]   cfg_rdata
);
    import cache_pkg::*;

    cache_ctl_t             ctl;
    cache_evt_t             evt;
    logic [3:0]             ram_we;     // Byte lanes
    logic [`RAM_ADDR_W-1:0] ram_addr;
    logic [`MEM_DATA_W-1:0] ram_wdata;
    logic [`MEM_DATA_W-1:0] ram_rdata;

    dcache_core core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .ctl       (ctl),
        .ram_rdata (ram_rdata),
        .rsp       (rsp),
        .ready     (ready),
        .evt       (evt),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata)
    );

    backing_ram ram_i (
        .clk   (clk),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    cache_ctrl_regs regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .evt       (evt),
        .cfg_rdata (cfg_rdata),
        .ctl       (ctl)
    );

endmodule

//--- dcache_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Direct mapped read cache with write through
// Strobe req only while ready is high and keep it aligned
// Write misses do not allocate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_cfg.svh"

module dcache_core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mem_access_pkg::mem_req_t req,
    input  cache_pkg::cache_ctl_t    ctl,
    input  logic [`MEM_DATA_W-1:0]   ram_rdata,
    output mem_access_pkg::mem_rsp_t rsp,
    output logic                     ready,
    output cache_pkg::cache_evt_t    evt,
    output logic [3:0]               ram_we,
    output logic [`RAM_ADDR_W-1:0]   ram_addr,
    output logic [`MEM_DATA_W-1:0]   ram_wdata
);
    import mem_access_pkg::*;
    import cache_pkg::*;

    logic [`CACHE_TAG_W-1:0] req_tag;
    logic [`LINE_IDX_W-1:0]  req_idx;
    logic [`LINE_OFF_W-1:0]  req_off;

    cache_line_t             lines [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid;    // Separate flops for one cycle invalidate
    cache_line_t             cur_line;
    logic                    hit;
    logic                    accept;
    logic                    acc_rd;
    logic                    acc_wr;
    logic [3:0]              byte_en;
    logic [`MEM_DATA_W-1:0]  wdata_rep;

    fill_state_e                             state;
    logic [`CACHE_TAG_W-1:0]                 fill_tag;
    logic [`LINE_IDX_W-1:0]                  fill_idx;
    logic [`LINE_OFF_W-1:0]                  fill_off;   // Requested word
    logic                                    fill_bypass;
    logic [`LINE_OFF_W:0]                    fill_cnt;   // Top bit marks last capture
    logic [`LINE_OFF_W-1:0]                  cap_off;
    logic                                    fill_done;
    logic                                    fill_wr;
    logic [`LINE_WORDS-1:0][`MEM_DATA_W-1:0] line_buf;
    logic                                    hit_rsp_q;
    logic [`MEM_DATA_W-1:0]                  hit_data_q;

    // Lookup
    assign {req_tag, req_idx, req_off} = req.addr[`MEM_ADDR_W-1:`BYTE_OFF_W];
    assign cur_line = lines[req_idx];
    assign hit      = valid[req_idx] && (cur_line.tag == req_tag);

    assign ready  = (state != ST_FILL);  // Respond state takes new requests
    assign accept = req.valid && ready;
    assign acc_rd = accept && !req.we;
    assign acc_wr = accept && req.we;

    assign evt = '{hit: acc_rd && ctl.enable && hit, miss: acc_rd && ctl.enable && !hit};

    // Byte lanes and replicated store data
    always_comb begin
        case (req.size)
            SIZE_BYTE: begin
                byte_en   = 4'b0001 << req.addr[1:0];
                wdata_rep = {(`MEM_DATA_W/8){req.wdata[7:0]}};
            end
            SIZE_HALF: begin
                byte_en   = 4'b0011 << {req.addr[1], 1'b0};
                wdata_rep = {(`MEM_DATA_W/16){req.wdata[15:0]}};
            end
            SIZE_WORD: begin
                byte_en   = 4'b1111;
                wdata_rep = req.wdata;
            end
            default: begin
                byte_en   = 4'b0000;
                wdata_rep = req.wdata;
            end
        endcase
    end

    // RAM port. Request address outside a fill, so a bypass read starts at acceptance
    always_comb begin
        ram_we    = 4'b0000;
        ram_addr  = req.addr[`MEM_ADDR_W-1:`BYTE_OFF_W];
        ram_wdata = wdata_rep;
        if (state == ST_FILL)
            ram_addr = {fill_tag, fill_idx, fill_cnt[`LINE_OFF_W-1:0]};  // Words 0 to 3
        else if (acc_wr)
            ram_we = byte_en;
    end

    assign fill_done = fill_cnt[`LINE_OFF_W];
    assign fill_wr   = (state == ST_FILL) && fill_done && !fill_bypass;
    assign cap_off   = fill_cnt[`LINE_OFF_W-1:0] - 1'b1;  // Word issued last cycle

    // FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            fill_cnt  <= '0;
            hit_rsp_q <= 1'b0;
        end else begin
            hit_rsp_q <= acc_rd && ctl.enable && hit;
            case (state)
                ST_FILL: begin
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_bypass || fill_done)
                        state <= ST_RESPOND;
                end
                default: begin  // Idle and respond accept alike
                    fill_cnt <= '0;
                    if (acc_rd && !(ctl.enable && hit))
                        state <= ST_FILL;
                    else
                        state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request latch, line buffer and hit data
    always_ff @(posedge clk) begin
        if (acc_rd) begin
            fill_tag    <= req_tag;
            fill_idx    <= req_idx;
            fill_off    <= req_off;
            fill_bypass <= !ctl.enable;
        end
        hit_data_q <= cur_line.data[req_off];
        if (state == ST_FILL) begin
            if (fill_bypass)
                line_buf[fill_off] <= ram_rdata;
            else if (fill_cnt != '0)
                line_buf[cap_off] <= ram_rdata;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (fill_wr) begin
            lines[fill_idx] <= {fill_tag, ram_rdata, line_buf[`LINE_WORDS-2:0]};  // Last word direct
        end else if (acc_wr && hit) begin
            for (int b = 0; b < `MEM_DATA_W / 8; b++) begin
                if (byte_en[b])
                    lines[req_idx].data[req_off][8*b +: 8] <= wdata_rep[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid <= '0;
        else if (ctl.invalidate)
            valid <= '0;  // Wins over a finishing fill
        else if (fill_wr)
            valid[fill_idx] <= 1'b1;
    end

    // Response
    always_comb begin
        rsp.valid = hit_rsp_q || (state == ST_RESPOND);
        rsp.rdata = (state == ST_RESPOND) ? line_buf[fill_off] : hit_data_q;
    end

endmodule

//--- filelist.f
+incdir+.
mem_access_pkg.sv
cache_pkg.sv
backing_ram.sv
cache_ctrl_regs.sv
dcache_core.sv
data_mem_top.sv
data_mem_asserts.sv
tb_data_mem.sv

//--- mem_access_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Processor side request and response types
// Sub-word loads return the full aligned word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mem_cfg.svh"

package mem_access_pkg;

    // Access width of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // One strobe per request, only while ready is high
    typedef struct packed {
        logic                   valid;
        logic                   we;     // 1 for a store
        access_size_e           size;
        logic [`MEM_ADDR_W-1:0] addr;   // Byte address, naturally aligned
        logic [`MEM_DATA_W-1:0] wdata;  // Low bytes used for sub-word stores
    } mem_req_t;

    // Read data strobe, never raised for stores
    typedef struct packed {
        logic                   valid;
        logic [`MEM_DATA_W-1:0] rdata;
    } mem_rsp_t;

endpackage

//--- mem_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes shared by RTL and testbench
// Assumes 32-bit words and power-of-two line and word counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

`define MEM_ADDR_W   14   // Byte address width
`define MEM_DATA_W   32   // Word width
`define CACHE_LINES  16   // Direct mapped
`define LINE_WORDS   4    // Words per cache line

// Address fields derived from the sizes above
`define BYTE_OFF_W   2
`define LINE_OFF_W   $clog2(`LINE_WORDS)
`define LINE_IDX_W   $clog2(`CACHE_LINES)
`define CACHE_TAG_W  (`MEM_ADDR_W - `LINE_IDX_W - `LINE_OFF_W - `BYTE_OFF_W)
`define RAM_ADDR_W   (`MEM_ADDR_W - `BYTE_OFF_W)   // Word address into the RAM
`define RAM_WORDS    (1 << `RAM_ADDR_W)

`endif

//--- tb_data_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Random traffic against a byte and tag model
// One request in flight at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "mem_cfg.svh"

module tb_data_mem;
    import mem_access_pkg::*;
    import cache_pkg::*;

    localparam int N_RANDOM   = 2000;
    localparam int TIMEOUT    = N_RANDOM * 8 + 200;  // Directed part fits in the margin
    localparam int LAT_HIT    = 1;
    localparam int LAT_MISS   = 6;
    localparam int LAT_BYPASS = 2;

    logic                   clk = 1'b0;
    logic                   rst_n;
    mem_req_t               req;
    mem_rsp_t               rsp;
    logic                   ready;
    logic                   cfg_we;
    cfg_reg_e               cfg_addr;
    logic [`MEM_DATA_W-1:0] cfg_wdata;
    logic [`MEM_DATA_W-1:0] cfg_rdata;
    int                     cyc = 0;

    // Reference model
    logic [7:0]              mem_model [1 << `MEM_ADDR_W];
    logic [`CACHE_TAG_W-1:0] tag_model [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_model;
    logic                    enable_model;
    logic [31:0]             hit_model;
    logic [31:0]             miss_model;

    data_mem_top data_mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .rsp       (rsp),
        .ready     (ready),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    bind dcache_core data_mem_asserts asserts_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .ready (ready),
        .rsp   (rsp)
    );

    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT)
            abort_run($sformatf("Timeout: run still busy after %0d cycles", cyc));
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    endtask

    // Little endian word from the byte model
    function automatic logic [31:0] model_word(input logic [`MEM_ADDR_W-1:0] addr);
        int base;
        base = {addr[`MEM_ADDR_W-1:2], 2'b00};
        return {mem_model[base+3], mem_model[base+2], mem_model[base+1], mem_model[base]};
    endfunction

    // 64 bytes in each of four tags, all on lines 0 to 3, so lines collide
    function automatic logic [`MEM_ADDR_W-1:0] rand_addr(input access_size_e size);
        logic [7:0]             w;
        logic [`MEM_ADDR_W-1:0] a;
        w = 8'($urandom_range(255));
        a = {4'd0, w[7:6], 2'd0, w[5:0]};
        if (size == SIZE_HALF)
            a[0] = 1'b0;
        else if (size == SIZE_WORD)
            a[1:0] = 2'b00;
        return a;
    endfunction

    // Returns at the edge that accepts the request
    task automatic send_req(input logic we, input access_size_e size,
                            input logic [`MEM_ADDR_W-1:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        req <= '{valid: 1'b1, we: we, size: size, addr: addr, wdata: wdata};
        @(negedge clk);
        assert (ready) else abort_run("Request offered while ready was low");
        @(posedge clk);
        req.valid <= 1'b0;
    endtask

    task automatic do_write(input access_size_e size, input logic [`MEM_ADDR_W-1:0] addr,
                            input logic [31:0] data);
        int nbytes;
        send_req(1'b1, size, addr, data);
        nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        for (int i = 0; i < nbytes; i++)
            mem_model[int'(addr) + i] = data[8*i +: 8];  // No allocation on a miss
    endtask

    task automatic do_read(input string name, input access_size_e size,
                           input logic [`MEM_ADDR_W-1:0] addr);
        logic [`CACHE_TAG_W-1:0] tag;
        logic [`LINE_IDX_W-1:0]  idx;
        int                      exp_lat;
        int                      lat;
        tag = addr[`MEM_ADDR_W-1:8];  // Tag above bit 7, index in bits 7 to 4
        idx = addr[7:4];
        if (!enable_model) begin
            exp_lat = LAT_BYPASS;
        end else if (valid_model[idx] && tag_model[idx] == tag) begin
            exp_lat   = LAT_HIT;
            hit_model = hit_model + 1;
        end else begin
            exp_lat          = LAT_MISS;
            miss_model       = miss_model + 1;
            valid_model[idx] = 1'b1;  // Whole line filled
            tag_model[idx]   = tag;
        end
        send_req(1'b0, size, addr, 32'h0);
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!rsp.valid && lat < 16);
        check_value({name, " latency"}, exp_lat, lat);
        check_value({name, " data"}, model_word(addr), rsp.rdata);
        assert (ready) else abort_run("Ready still low when the read response arrived");
    endtask

    task automatic cfg_read(input cfg_reg_e addr, output logic [31:0] data);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        data = cfg_rdata;
    endtask

    task automatic cfg_write(input logic [31:0] data);
        @(posedge clk);
        cfg_we    <= 1'b1;
        cfg_addr  <= REG_CTRL;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_we <= 1'b0;
        enable_model = data[0];
        hit_model    = '0;   // Any ctrl write clears both counters
        miss_model   = '0;
        if (data[1])
            valid_model = '0;
    endtask

    task automatic check_counters(input string name);
        logic [31:0] v;
        cfg_read(REG_HIT_COUNT, v);
        check_value({name, " hits"}, hit_model, v);
        cfg_read(REG_MISS_COUNT, v);
        check_value({name, " misses"}, miss_model, v);
        cfg_read(REG_CTRL, v);
        check_value({name, " ctrl"}, {31'b0, enable_model}, v);
    endtask

    initial begin
        void'($urandom(32'h66450385));
        rst_n     = 1'b0;
        req       = '0;
        cfg_we    = 1'b0;
        cfg_addr  = REG_CTRL;
        cfg_wdata = '0;
        for (int i = 0; i < (1 << `MEM_ADDR_W); i++)
            mem_model[i] = 8'h00;  // RAM starts cleared
        valid_model  = '0;
        enable_model = 1'b1;
        hit_model    = '0;
        miss_model   = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (ready && !rsp.valid) else abort_run("Wrong ready or response after reset");
        check_counters("reset");

        // Miss fills the line, neighbours hit
        for (int i = 0; i < 4; i++)
            do_write(SIZE_WORD, 14'h040 + 14'(4 * i), 32'h1111_0000 + 32'(i));
        do_read("line fill", SIZE_WORD, 14'h040);
        do_read("line word 1", SIZE_HALF, 14'h046);
        do_read("line word 2", SIZE_BYTE, 14'h049);
        do_read("line word 3", SIZE_WORD, 14'h04C);
        check_counters("line fill");

        // Write hit then read back
        do_write(SIZE_BYTE, 14'h045, 32'h0000_00A5);
        do_read("write hit", SIZE_WORD, 14'h044);
        check_counters("write hit");

        // Invalidate then bypass
        cfg_write(32'h3);
        check_counters("invalidate");
        do_read("after invalidate", SIZE_WORD, 14'h040);
        cfg_write(32'h0);
        do_read("bypass", SIZE_WORD, 14'h048);
        check_counters("bypass");
        cfg_write(32'h1);

        for (int n = 0; n < N_RANDOM; n++) begin
            int                     r;
            access_size_e           sz;
            logic [`MEM_ADDR_W-1:0] a;
            r  = $urandom_range(99);
            sz = access_size_e'($urandom_range(2));
            a  = rand_addr(sz);
            if (r < 45) begin
                do_read($sformatf("random op %0d", n), sz, a);
            end else if (r < 85) begin
                do_write(sz, a, $urandom());
            end else if (r < 90) begin
                check_counters($sformatf("random op %0d", n));
            end else if (r < 95) begin
                cfg_write({30'b0, 1'b1, enable_model});  // Invalidate, keep enable
                check_counters($sformatf("invalidate op %0d", n));
            end else begin
                cfg_write({31'b0, !enable_model});
            end
        end
        check_counters("final");

        $display("Finished with no errors");
        $finish;
    end

endmodule
